// File: common/fetch_pkg.sv
// ------------------------------------------------
// fetch package
// address types, executable regions, predictor sizes
// and the structs shared by the instruction fetch unit
// ------------------------------------------------
package fetch_pkg;

    // address widths
    localparam int PC_BITS    = 64;
    localparam int VADDR_BITS = 40;
    localparam int VA_BITS    = 39;

    typedef logic [PC_BITS-1:0]    addr_pc_t;
    typedef logic [VADDR_BITS-1:0] vaddr_t;

    localparam addr_pc_t RESET_ADDR = 64'h0000_0000_0001_0000;

    // executable regions with exclusive end
    localparam addr_pc_t DEB_BASE  = 64'h0000_0000_0000_0000;
    localparam addr_pc_t DEB_END   = 64'h0000_0000_0000_1000;
    localparam addr_pc_t ROM_BASE  = 64'h0000_0000_0001_0000;
    localparam addr_pc_t ROM_END   = 64'h0000_0000_0002_0000;
    localparam addr_pc_t DRAM_BASE = 64'h0000_0000_8000_0000;
    localparam addr_pc_t DRAM_END  = 64'h0000_0000_C000_0000;

    // predictor geometry
    localparam int BP_INDEX_BITS = 6;
    localparam int BP_ENTRIES    = 1 << BP_INDEX_BITS;
    localparam int BP_IDX_LSB    = 2;
    localparam int BP_TAG_LSB    = BP_IDX_LSB + BP_INDEX_BITS;
    localparam int BP_TAG_BITS   = 32;

    typedef enum logic [1:0] {
        NEXT_PC_SEL_KEEP_PC    = 2'd0,
        NEXT_PC_SEL_BP_OR_PC_4 = 2'd1,
        NEXT_PC_SEL_JUMP       = 2'd2,
        NEXT_PC_SEL_DEBUG      = 2'd3
    } next_pc_sel_e;

    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } pred_decision_e;

    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1
    } xcpt_cause_e;

    typedef struct packed {
        next_pc_sel_e next_pc;
    } cu_if_t;

    // training port from execute
    typedef struct packed {
        addr_pc_t pc_execution;
        addr_pc_t branch_addr_result;
        logic     branch_taken_result;
        logic     is_branch;
    } exe_if_branch_pred_t;

    typedef struct packed {
        logic   valid;
        vaddr_t vaddr;
        logic   invalidate_icache;
        logic   invalidate_buffer;
        logic   inval_fetch;
    } req_cpu_icache_t;

    typedef struct packed {
        xcpt_cause_e cause;
        addr_pc_t    origin;
        logic        valid;
    } exception_t;

    typedef struct packed {
        logic           is_branch;
        pred_decision_e decision;
        addr_pc_t       pred_addr;
    } bpred_t;

    // stage record handed to the next fetch stage
    typedef struct packed {
        addr_pc_t   pc_inst;
        logic       valid;
        exception_t ex;
        bpred_t     bpred;
    } fetch_rec_t;

    // predictor entry payload without the valid bit
    typedef struct packed {
        logic [BP_TAG_BITS-1:0] tag;
        addr_pc_t               target;
        logic [1:0]             cnt;
    } bp_entry_t;

endpackage

// File: branch_predictor/branch_predictor.sv
// ------------------------------------------------
// branch predictor
// direct-mapped table of tags, targets and 2-bit
// counters, looked up by fetch and trained by execute
// ------------------------------------------------
module branch_predictor (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  fetch_pkg::addr_pc_t            pc_fetch_i,
    input  fetch_pkg::exe_if_branch_pred_t exe_if_branch_pred_i,
    output fetch_pkg::bpred_t              pred_o
);

    localparam int IDX_HI = fetch_pkg::BP_TAG_LSB - 1;
    localparam int TAG_HI = fetch_pkg::BP_TAG_LSB + fetch_pkg::BP_TAG_BITS - 1;

    logic [fetch_pkg::BP_ENTRIES-1:0] valid_q;
    fetch_pkg::bp_entry_t             table_q [fetch_pkg::BP_ENTRIES];

    logic [fetch_pkg::BP_INDEX_BITS-1:0] rd_idx;
    logic [fetch_pkg::BP_TAG_BITS-1:0]   rd_tag;
    logic                                rd_hit;
    fetch_pkg::bp_entry_t                rd_entry;

    logic [fetch_pkg::BP_INDEX_BITS-1:0] wr_idx;
    logic [fetch_pkg::BP_TAG_BITS-1:0]   wr_tag;
    logic                                wr_hit;
    logic                                wr_taken;
    fetch_pkg::bp_entry_t                wr_entry;

    // lookup from the fetch pc
    assign rd_idx   = pc_fetch_i[IDX_HI:fetch_pkg::BP_IDX_LSB];
    assign rd_tag   = pc_fetch_i[TAG_HI:fetch_pkg::BP_TAG_LSB];
    assign rd_entry = table_q[rd_idx];
    assign rd_hit   = valid_q[rd_idx] && (rd_entry.tag == rd_tag);

    assign pred_o.is_branch = rd_hit;
    assign pred_o.decision  = (rd_hit && rd_entry.cnt[1]) ? fetch_pkg::PRED_TAKEN
                                                           : fetch_pkg::PRED_NOT_TAKEN;
    assign pred_o.pred_addr = rd_hit ? rd_entry.target : '0;

    // training entry from execute
    assign wr_idx   = exe_if_branch_pred_i.pc_execution[IDX_HI:fetch_pkg::BP_IDX_LSB];
    assign wr_tag   = exe_if_branch_pred_i.pc_execution[TAG_HI:fetch_pkg::BP_TAG_LSB];
    assign wr_taken = exe_if_branch_pred_i.branch_taken_result;
    assign wr_hit   = valid_q[wr_idx] && (table_q[wr_idx].tag == wr_tag);

    always_comb begin
        wr_entry = table_q[wr_idx];
        if (!wr_hit) begin
            // new branch starts weakly biased toward the outcome
            wr_entry.tag    = wr_tag;
            wr_entry.target = exe_if_branch_pred_i.branch_addr_result;
            wr_entry.cnt    = wr_taken ? 2'd2 : 2'd1;
        end else if (wr_taken) begin
            wr_entry.target = exe_if_branch_pred_i.branch_addr_result;
            if (wr_entry.cnt != 2'd3) begin
                wr_entry.cnt = wr_entry.cnt + 2'd1;
            end
        end else if (wr_entry.cnt != 2'd0) begin
            wr_entry.cnt = wr_entry.cnt - 2'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exe_if_branch_pred_i.is_branch) begin
            table_q[wr_idx] <= wr_entry;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (exe_if_branch_pred_i.is_branch) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // execute only reports branches at word-aligned pcs
    a_train_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        exe_if_branch_pred_i.is_branch |-> exe_if_branch_pred_i.pc_execution[1:0] == 2'b00)
        else $error("branch trained at misaligned pc");

endmodule

// File: hdl/fetch_pc_stage.sv
// ------------------------------------------------
// fetch pc stage
// pc register and next-pc select, address checks,
// icache request and the fetch stage record
// ------------------------------------------------
module fetch_pc_stage (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           stall_i,
    input  logic                           stall_debug_i,
    input  fetch_pkg::cu_if_t              cu_if_i,
    input  logic                           invalidate_icache_i,
    input  logic                           invalidate_buffer_i,
    input  logic                           en_translation_i,
    input  logic                           retry_fetch_i,
    input  fetch_pkg::addr_pc_t            pc_jump_i,
    input  fetch_pkg::exe_if_branch_pred_t exe_if_branch_pred_i,
    output fetch_pkg::req_cpu_icache_t     req_cpu_icache_o,
    output fetch_pkg::fetch_rec_t          fetch_o
);

    fetch_pkg::addr_pc_t pc_q;
    fetch_pkg::addr_pc_t next_pc;
    fetch_pkg::bpred_t   pred;

    logic in_rom;
    logic in_dram;
    logic in_deb;
    logic in_exe_region;
    logic canonical;
    logic misaligned;
    logic access_fault;
    logic no_stall;

    branch_predictor u_branch_predictor (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .pc_fetch_i           (pc_q),
        .exe_if_branch_pred_i (exe_if_branch_pred_i),
        .pred_o               (pred)
    );

    // the control unit holds the pc with keep
    always_comb begin
        unique case (cu_if_i.next_pc)
            fetch_pkg::NEXT_PC_SEL_KEEP_PC: begin
                next_pc = pc_q;
            end
            fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4: begin
                if (pred.is_branch && pred.decision == fetch_pkg::PRED_TAKEN) begin
                    next_pc = pred.pred_addr;
                end else begin
                    next_pc = pc_q + 64'd4;
                end
            end
            fetch_pkg::NEXT_PC_SEL_JUMP,
            fetch_pkg::NEXT_PC_SEL_DEBUG: begin
                next_pc = pc_jump_i;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= fetch_pkg::RESET_ADDR;
        end else begin
            pc_q <= next_pc;
        end
    end

    // region and canonical checks
    assign in_rom  = (pc_q >= fetch_pkg::ROM_BASE) && (pc_q < fetch_pkg::ROM_END);
    assign in_dram = (pc_q >= fetch_pkg::DRAM_BASE) && (pc_q < fetch_pkg::DRAM_END);
    assign in_deb  = (pc_q >= fetch_pkg::DEB_BASE) && (pc_q < fetch_pkg::DEB_END);
    assign in_exe_region = in_rom || in_dram || in_deb;

    // upper bits must copy bit 38
    assign canonical = (&pc_q[63:fetch_pkg::VA_BITS-1]) || !(|pc_q[63:fetch_pkg::VA_BITS-1]);

    assign misaligned   = |pc_q[1:0];
    assign access_fault = en_translation_i ? !canonical : !in_exe_region;
    assign no_stall     = !stall_i && !stall_debug_i;

    // icache request
    assign req_cpu_icache_o.valid             = !misaligned && !access_fault && no_stall;
    assign req_cpu_icache_o.vaddr             = pc_q[fetch_pkg::VADDR_BITS-1:0];
    assign req_cpu_icache_o.invalidate_icache = invalidate_icache_i;
    assign req_cpu_icache_o.invalidate_buffer = invalidate_buffer_i | retry_fetch_i;
    assign req_cpu_icache_o.inval_fetch       = retry_fetch_i;

    // misaligned wins over access fault in the stage record
    assign fetch_o.pc_inst   = pc_q;
    assign fetch_o.valid     = no_stall;
    assign fetch_o.ex.cause  = misaligned ? fetch_pkg::INSTR_ADDR_MISALIGNED
                             : access_fault ? fetch_pkg::INSTR_ACCESS_FAULT
                             : fetch_pkg::INSTR_ADDR_MISALIGNED;
    assign fetch_o.ex.origin = pc_q;
    assign fetch_o.ex.valid  = misaligned || access_fault;
    assign fetch_o.bpred     = pred;

endmodule

// File: hdl/fetch_out_stage.sv
// ------------------------------------------------
// fetch output stage
// registers the stage record with flush over stall hold
// ------------------------------------------------
module fetch_out_stage (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  stall_i,
    input  logic                  stall_debug_i,
    input  logic                  flush_i,
    input  fetch_pkg::fetch_rec_t rec_i,
    output fetch_pkg::fetch_rec_t rec_o
);

    logic                  hold;
    logic                  valid_q;
    logic                  xcpt_valid_q;
    fetch_pkg::fetch_rec_t data_q;

    assign hold = stall_i || stall_debug_i;

    // valid bits carry the reset and the flush
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q      <= 1'b0;
            xcpt_valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q      <= 1'b0;
            xcpt_valid_q <= 1'b0;
        end else if (!hold) begin
            valid_q      <= rec_i.valid;
            xcpt_valid_q <= rec_i.ex.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold) begin
            data_q <= rec_i;
        end
    end

    always_comb begin
        rec_o          = data_q;
        rec_o.valid    = valid_q;
        rec_o.ex.valid = xcpt_valid_q;
    end

    a_flush_kills: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !rec_o.valid)
        else $error("record still valid after flush");

    // cause ordering is done in the pc stage
    a_misaligned_first: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rec_o.ex.valid && |rec_o.ex.origin[1:0])
            |-> rec_o.ex.cause == fetch_pkg::INSTR_ADDR_MISALIGNED)
        else $error("misaligned pc reported with wrong cause");

endmodule

// File: hdl/fetch_top.sv
// ------------------------------------------------
// fetch top
// pc stage with predictor plus the output register
// ------------------------------------------------
module fetch_top (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           stall_i,
    input  logic                           stall_debug_i,
    input  logic                           flush_i,
    input  fetch_pkg::cu_if_t              cu_if_i,
    input  logic                           invalidate_icache_i,
    input  logic                           invalidate_buffer_i,
    input  logic                           en_translation_i,
    input  fetch_pkg::addr_pc_t            pc_jump_i,
    input  fetch_pkg::exe_if_branch_pred_t exe_if_branch_pred_i,
    input  logic                           retry_fetch_i,
    output fetch_pkg::req_cpu_icache_t     req_cpu_icache_o,
    output fetch_pkg::fetch_rec_t          fetch_o
);

    fetch_pkg::fetch_rec_t pc_rec;

    fetch_pc_stage u_fetch_pc_stage (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .stall_i              (stall_i),
        .stall_debug_i        (stall_debug_i),
        .cu_if_i              (cu_if_i),
        .invalidate_icache_i  (invalidate_icache_i),
        .invalidate_buffer_i  (invalidate_buffer_i),
        .en_translation_i     (en_translation_i),
        .retry_fetch_i        (retry_fetch_i),
        .pc_jump_i            (pc_jump_i),
        .exe_if_branch_pred_i (exe_if_branch_pred_i),
        .req_cpu_icache_o     (req_cpu_icache_o),
        .fetch_o              (pc_rec)
    );

    fetch_out_stage u_fetch_out_stage (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stall_i       (stall_i),
        .stall_debug_i (stall_debug_i),
        .flush_i       (flush_i),
        .rec_i         (pc_rec),
        .rec_o         (fetch_o)
    );

endmodule

// File: sim/tb_fetch_ref.svh
// ------------------------------------------------
// fetch reference model
// expected pc, exceptions and predictor table, plus
// the compare tasks for the request and the record
// ------------------------------------------------
`ifndef TB_FETCH_REF_SVH
`define TB_FETCH_REF_SVH

    // predictor copy indexed by pc[7:2] and tagged by pc[39:8]
    logic                tbl_valid  [64];
    logic [31:0]         tbl_tag    [64];
    fetch_pkg::addr_pc_t tbl_target [64];
    logic [1:0]          tbl_cnt    [64];

    task automatic clear_table();
        tbl_valid = '{default: 1'b0};
    endtask

    task automatic train_table(input fetch_pkg::exe_if_branch_pred_t tr);
        logic [5:0] idx;
        logic       hit;
        idx = tr.pc_execution[7:2];
        hit = tbl_valid[idx] && (tbl_tag[idx] == tr.pc_execution[39:8]);
        if (!hit) begin
            tbl_valid[idx]  = 1'b1;
            tbl_tag[idx]    = tr.pc_execution[39:8];
            tbl_target[idx] = tr.branch_addr_result;
            tbl_cnt[idx]    = tr.branch_taken_result ? 2'd2 : 2'd1;
        end else if (tr.branch_taken_result) begin
            tbl_target[idx] = tr.branch_addr_result;
            if (tbl_cnt[idx] < 2'd3) begin
                tbl_cnt[idx] = tbl_cnt[idx] + 2'd1;
            end
        end else if (tbl_cnt[idx] > 2'd0) begin
            tbl_cnt[idx] = tbl_cnt[idx] - 2'd1;
        end
    endtask

    function automatic fetch_pkg::bpred_t lookup_table(input fetch_pkg::addr_pc_t pc);
        fetch_pkg::bpred_t p;
        logic [5:0]        idx;
        idx = pc[7:2];
        p   = '0;
        if (tbl_valid[idx] && (tbl_tag[idx] == pc[39:8])) begin
            p.is_branch = 1'b1;
            p.pred_addr = tbl_target[idx];
            p.decision  = (tbl_cnt[idx] >= 2'd2) ? fetch_pkg::PRED_TAKEN
                                                  : fetch_pkg::PRED_NOT_TAKEN;
        end
        return p;
    endfunction

    function automatic logic fetch_fault(input fetch_pkg::addr_pc_t pc);
        logic inside_any;
        inside_any = (pc >= fetch_pkg::ROM_BASE && pc < fetch_pkg::ROM_END)
                  || (pc >= fetch_pkg::DRAM_BASE && pc < fetch_pkg::DRAM_END)
                  || (pc >= fetch_pkg::DEB_BASE && pc < fetch_pkg::DEB_END);
        // sv39 needs the upper bits to sign extend bit 38
        if (en_translation_i) begin
            return pc != {{25{pc[38]}}, pc[38:0]};
        end
        return !inside_any;
    endfunction

    function automatic fetch_pkg::req_cpu_icache_t expected_req(input fetch_pkg::addr_pc_t pc);
        fetch_pkg::req_cpu_icache_t r;
        logic                       bad;
        bad                 = (pc[1:0] != 2'b00) || fetch_fault(pc);
        r.valid             = !bad && !stall_i && !stall_debug_i;
        r.vaddr             = pc[39:0];
        r.invalidate_icache = invalidate_icache_i;
        r.invalidate_buffer = invalidate_buffer_i || retry_fetch_i;
        r.inval_fetch       = retry_fetch_i;
        return r;
    endfunction

    function automatic fetch_pkg::fetch_rec_t expected_rec(input fetch_pkg::addr_pc_t pc);
        fetch_pkg::fetch_rec_t r;
        r.pc_inst   = pc;
        r.valid     = !stall_i && !stall_debug_i;
        r.ex.valid  = (pc[1:0] != 2'b00) || fetch_fault(pc);
        r.ex.cause  = (pc[1:0] != 2'b00) ? fetch_pkg::INSTR_ADDR_MISALIGNED
                                         : fetch_pkg::INSTR_ACCESS_FAULT;
        r.ex.origin = pc;
        r.bpred     = lookup_table(pc);
        return r;
    endfunction

    function automatic fetch_pkg::addr_pc_t select_next_pc(input fetch_pkg::addr_pc_t pc);
        fetch_pkg::bpred_t p;
        p = lookup_table(pc);
        case (cu_if_i.next_pc)
            fetch_pkg::NEXT_PC_SEL_KEEP_PC: return pc;
            fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4: begin
                if (p.is_branch && p.decision == fetch_pkg::PRED_TAKEN) begin
                    return p.pred_addr;
                end
                return pc + 64'd4;
            end
            default: return pc_jump_i;
        endcase
    endfunction

    task automatic compare_field(input string field, input logic [63:0] got,
                                 input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0d ns: %s got %0h expected %0h", $time, field, got, exp);
        end
    endtask

    task automatic check_req(input fetch_pkg::req_cpu_icache_t got,
                             input fetch_pkg::req_cpu_icache_t exp);
        compare_field("req.valid", 64'(got.valid), 64'(exp.valid));
        compare_field("req.vaddr", 64'(got.vaddr), 64'(exp.vaddr));
        compare_field("req.invalidate_icache", 64'(got.invalidate_icache),
                      64'(exp.invalidate_icache));
        compare_field("req.invalidate_buffer", 64'(got.invalidate_buffer),
                      64'(exp.invalidate_buffer));
        compare_field("req.inval_fetch", 64'(got.inval_fetch), 64'(exp.inval_fetch));
    endtask

    task automatic check_rec(input fetch_pkg::fetch_rec_t got, input fetch_pkg::fetch_rec_t exp);
        compare_field("rec.valid", 64'(got.valid), 64'(exp.valid));
        compare_field("rec.ex.valid", 64'(got.ex.valid), 64'(exp.ex.valid));
        // contents only matter for a valid record
        if (exp.valid) begin
            compare_field("rec.pc_inst", got.pc_inst, exp.pc_inst);
            compare_field("rec.bpred.is_branch", 64'(got.bpred.is_branch),
                          64'(exp.bpred.is_branch));
            compare_field("rec.bpred.decision", 64'(got.bpred.decision),
                          64'(exp.bpred.decision));
            compare_field("rec.bpred.pred_addr", got.bpred.pred_addr, exp.bpred.pred_addr);
            if (exp.ex.valid) begin
                compare_field("rec.ex.cause", 64'(got.ex.cause), 64'(exp.ex.cause));
                compare_field("rec.ex.origin", got.ex.origin, exp.ex.origin);
            end
        end
    endtask

`endif

// File: sim/tb_fetch_top.sv
// ------------------------------------------------
// fetch unit testbench
// sequential fetch, jumps, exceptions, prediction,
// stall, flush and cache control against a reference
// ------------------------------------------------
module tb_fetch_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic                           clk_i;
    logic                           rstn_i;
    logic                           stall_i;
    logic                           stall_debug_i;
    logic                           flush_i;
    fetch_pkg::cu_if_t              cu_if_i;
    logic                           invalidate_icache_i;
    logic                           invalidate_buffer_i;
    logic                           en_translation_i;
    fetch_pkg::addr_pc_t            pc_jump_i;
    fetch_pkg::exe_if_branch_pred_t exe_if_branch_pred_i;
    logic                           retry_fetch_i;
    fetch_pkg::req_cpu_icache_t     req_cpu_icache_o;
    fetch_pkg::fetch_rec_t          fetch_o;

    integer                seed;
    int                    n_checks;
    int                    n_errors;
    int                    err_mark;
    logic [31:0]           rnd;
    fetch_pkg::addr_pc_t   ref_pc;
    fetch_pkg::fetch_rec_t ref_out;
    fetch_pkg::addr_pc_t   br  [4];
    fetch_pkg::addr_pc_t   tgt [4];

    `include "tb_fetch_ref.svh"

    fetch_top i_dut (.*);

    always #4 clk_i = ~clk_i;

    // reference state moves on the same edge as the dut
    always @(posedge clk_i or negedge rstn_i) begin
        fetch_pkg::fetch_rec_t rec;
        if (!rstn_i) begin
            ref_pc           = fetch_pkg::RESET_ADDR;
            ref_out.valid    = 1'b0;
            ref_out.ex.valid = 1'b0;
            clear_table();
        end else begin
            rec = expected_rec(ref_pc);
            if (flush_i) begin
                ref_out.valid    = 1'b0;
                ref_out.ex.valid = 1'b0;
            end else if (!(stall_i || stall_debug_i)) begin
                ref_out = rec;
            end
            ref_pc = select_next_pc(ref_pc);
            if (exe_if_branch_pred_i.is_branch) begin
                train_table(exe_if_branch_pred_i);
            end
        end
    end

    // compare mid-cycle when inputs and outputs have settled
    always @(negedge clk_i) begin
        if (rstn_i) begin
            check_req(req_cpu_icache_o, expected_req(ref_pc));
            check_rec(fetch_o, ref_out);
        end
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_vaddr(input fetch_pkg::addr_pc_t pc, input int limit);
        int n;
        n = 0;
        @(negedge clk_i);
        while (req_cpu_icache_o.vaddr !== pc[39:0] && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (req_cpu_icache_o.vaddr !== pc[39:0]) begin
            n_errors++;
            $display("timeout: fetch never reached pc %0h within %0d cycles", pc, limit);
        end
    endtask

    task automatic wait_out_valid(input int limit);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!fetch_o.valid && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (!fetch_o.valid) begin
            n_errors++;
            $display("timeout: fetch_o did not turn valid within %0d cycles", limit);
        end
    endtask

    // one cycle of jump or debug select followed by keep
    task automatic jump_to(input fetch_pkg::addr_pc_t pc, input fetch_pkg::next_pc_sel_e sel);
        next_cycle();
        cu_if_i.next_pc = sel;
        pc_jump_i       = pc;
        next_cycle();
        cu_if_i.next_pc = fetch_pkg::NEXT_PC_SEL_KEEP_PC;
        wait_vaddr(pc, 2);
    endtask

    task automatic train(input fetch_pkg::addr_pc_t pc, input fetch_pkg::addr_pc_t target,
                         input logic taken);
        next_cycle();
        exe_if_branch_pred_i.pc_execution        = pc;
        exe_if_branch_pred_i.branch_addr_result  = target;
        exe_if_branch_pred_i.branch_taken_result = taken;
        exe_if_branch_pred_i.is_branch           = 1'b1;
        next_cycle();
        exe_if_branch_pred_i.is_branch = 1'b0;
    endtask

    task automatic open_test();
        err_mark = n_errors;
    endtask

    task automatic close_test(input string name);
        $display("test %s finished with %0d errors", name, n_errors - err_mark);
    endtask

    initial begin
        seed                 = 32'h13a0;
        n_checks             = 0;
        n_errors             = 0;
        err_mark             = 0;
        clk_i                = 1'b0;
        rstn_i               = 1'b0;
        stall_i              = 1'b0;
        stall_debug_i        = 1'b0;
        flush_i              = 1'b0;
        cu_if_i.next_pc      = fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
        invalidate_icache_i  = 1'b0;
        invalidate_buffer_i  = 1'b0;
        en_translation_i     = 1'b0;
        retry_fetch_i        = 1'b0;
        pc_jump_i            = '0;
        exe_if_branch_pred_i = '0;
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        open_test();
        wait_vaddr(fetch_pkg::RESET_ADDR, 1);
        wait_out_valid(4);
        wait_vaddr(fetch_pkg::RESET_ADDR + 64'h40, 20);
        close_test("sequential fetch");

        open_test();
        jump_to(fetch_pkg::DRAM_BASE + 64'h1240, fetch_pkg::NEXT_PC_SEL_JUMP);
        repeat (3) next_cycle();
        wait_vaddr(fetch_pkg::DRAM_BASE + 64'h1240, 1);
        jump_to(fetch_pkg::DEB_BASE + 64'h40, fetch_pkg::NEXT_PC_SEL_DEBUG);
        next_cycle();
        cu_if_i.next_pc = fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
        wait_vaddr(fetch_pkg::DEB_BASE + 64'h50, 8);
        close_test("jump, debug and keep");

        open_test();
        jump_to(fetch_pkg::DRAM_BASE + 64'h2, fetch_pkg::NEXT_PC_SEL_JUMP);
        // hole between rom and dram
        jump_to(64'h0000_0000_4000_0000, fetch_pkg::NEXT_PC_SEL_JUMP);
        next_cycle();
        en_translation_i = 1'b1;
        jump_to(64'h0000_0080_0000_0000, fetch_pkg::NEXT_PC_SEL_JUMP);
        jump_to(64'hffff_ffc0_0000_1000, fetch_pkg::NEXT_PC_SEL_JUMP);
        next_cycle();
        en_translation_i = 1'b0;
        jump_to(64'h0000_0000_4000_0002, fetch_pkg::NEXT_PC_SEL_JUMP);
        close_test("exceptions");

        open_test();
        // one branch per table index so none evicts another
        for (int k = 0; k < 4; k++) begin
            rnd    = $random(seed);
            br[k]  = fetch_pkg::DRAM_BASE + {36'h0, rnd[27:8], 6'(k), 2'b00};
            rnd    = $random(seed);
            tgt[k] = fetch_pkg::DRAM_BASE + 64'h2000_0000 + {36'h0, rnd[27:2], 2'b00};
            train(br[k], tgt[k], 1'b1);
        end
        for (int k = 0; k < 4; k++) begin
            jump_to(br[k], fetch_pkg::NEXT_PC_SEL_JUMP);
            next_cycle();
            cu_if_i.next_pc = fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
            wait_vaddr(tgt[k], 3);
        end
        train(br[0], tgt[0], 1'b1);
        train(br[0], tgt[0], 1'b0);
        train(br[0], tgt[0], 1'b0);
        jump_to(br[0], fetch_pkg::NEXT_PC_SEL_JUMP);
        next_cycle();
        cu_if_i.next_pc = fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
        wait_vaddr(br[0] + 64'd4, 3);
        // bit 28 is part of the tag and clear in every trained pc
        jump_to(br[1] ^ 64'h1000_0000, fetch_pkg::NEXT_PC_SEL_JUMP);
        next_cycle();
        cu_if_i.next_pc = fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
        wait_vaddr((br[1] ^ 64'h1000_0000) + 64'd4, 3);
        close_test("prediction");

        open_test();
        next_cycle();
        cu_if_i.next_pc = fetch_pkg::NEXT_PC_SEL_KEEP_PC;
        stall_i         = 1'b1;
        repeat (3) next_cycle();
        stall_i       = 1'b0;
        stall_debug_i = 1'b1;
        repeat (2) next_cycle();
        stall_debug_i   = 1'b0;
        cu_if_i.next_pc = fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
        next_cycle();
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        wait_out_valid(4);
        close_test("stall and flush");

        open_test();
        next_cycle();
        invalidate_icache_i = 1'b1;
        next_cycle();
        invalidate_icache_i = 1'b0;
        invalidate_buffer_i = 1'b1;
        next_cycle();
        invalidate_buffer_i = 1'b0;
        retry_fetch_i       = 1'b1;
        next_cycle();
        retry_fetch_i = 1'b0;
        wait_out_valid(2);
        close_test("cache control");

        $display("all tests done: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+sim
common/fetch_pkg.sv
branch_predictor/branch_predictor.sv
hdl/fetch_pc_stage.sv
hdl/fetch_out_stage.sv
hdl/fetch_top.sv
sim/tb_fetch_top.sv

// File: Makefile
# Verilator build and run of the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, output in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
